//--- bench/riscv_controller_checker.sv
////////////////////////////////////////////////////////////
// riscv controller checker
// concurrent assertions on boot, forwarding, stalls, traps
// and the flush to sleep sequence, bound into the top level
////////////////////////////////////////////////////////////

module riscv_controller_checker (
  input logic clk, rst_n, fetch_enable_i, instr_valid_i, mret_insn_i,
  input logic pipe_flush_i, branch_taken_ex_i, int_req_i, ext_req_i,
  input logic id_ready_i, data_req_ex_i, data_misaligned_i, csr_busy_i, csr_access_id_i,
  input logic mult_multicycle_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i,
  input logic reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i,
  input logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i,
  input logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i,
  input logic ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o,
  input logic exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o,
  input logic exc_restore_id_o, halt_if_o, halt_id_o, load_stall_o, csr_stall_o, jr_stall_o,
  input riscv_ctrl_pkg::jump_kind_e  jump_in_dec_i,
  input riscv_ctrl_pkg::pc_sel_e     pc_mux_o,
  input riscv_ctrl_pkg::fw_sel_e     operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o,
  input riscv_ctrl_pkg::fw_sel_e     operand_c_fw_mux_sel_o,
  input riscv_ctrl_pkg::ctrl_state_e fsm_state_i
);

  import riscv_ctrl_pkg::*;

  logic in_decode;
  logic pc_boot;
  logic pc_jump;
  logic exc_entry;
  logic rega_busy;

  // newest writer wins, ALU forward path over WB over regfile
  function automatic logic [1:0] newest_src(input logic alu_hit, input logic wb_hit);
    return alu_hit ? SEL_FW_EX : (wb_hit ? SEL_FW_WB : SEL_REGFILE);
  endfunction

  // valid instruction in ID with nothing taken in EX
  assign in_decode = fsm_state_i == DECODE && instr_valid_i && !branch_taken_ex_i;
  assign pc_boot   = pc_set_o && pc_mux_o == PC_BOOT;
  assign pc_jump   = pc_set_o && pc_mux_o == PC_JUMP;
  assign exc_entry = pc_set_o && pc_mux_o == PC_EXCEPTION && exc_ack_o && halt_id_o;
  // register a still owed by WB, EX or the ALU path
  assign rega_busy = (regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
                     (regfile_we_ex_i && reg_d_ex_is_reg_a_i) ||
                     (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i);

  ////////////////////////////////////////////////////////////
  // boot
  ////////////////////////////////////////////////////////////
  a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n) fsm_state_i == RESET |->
    !(instr_req_o || ctrl_busy_o || pc_set_o || exc_ack_o || irq_ack_o || halt_if_o || halt_id_o))
    else $error("outputs active in RESET");
  a_boot_next: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == RESET && fetch_enable_i |=> pc_boot) else $error("no boot pc set");
  a_boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == BOOT_SET |=> !pc_boot) else $error("boot pc set held too long");
  a_boot_only: assert property (@(posedge clk) disable iff (!rst_n)
    pc_boot |-> fsm_state_i == BOOT_SET) else $error("boot pc set outside BOOT_SET");

  ////////////////////////////////////////////////////////////
  // forwarding and stalls
  ////////////////////////////////////////////////////////////
  a_fw_a: assert property (@(posedge clk) disable iff (!rst_n) operand_a_fw_mux_sel_o ==
    (data_misaligned_i ? SEL_FW_EX : newest_src(regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i,
    regfile_we_wb_i && reg_d_wb_is_reg_a_i))) else $error("wrong operand a select");
  a_fw_b: assert property (@(posedge clk) disable iff (!rst_n) operand_b_fw_mux_sel_o ==
    (data_misaligned_i ? SEL_REGFILE : newest_src(regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i,
    regfile_we_wb_i && reg_d_wb_is_reg_b_i))) else $error("wrong operand b select");
  a_fw_c: assert property (@(posedge clk) disable iff (!rst_n) operand_c_fw_mux_sel_o ==
    ((!data_misaligned_i && mult_multicycle_i) ? SEL_FW_EX : newest_src(regfile_alu_we_fw_i &&
    reg_d_alu_is_reg_c_i, regfile_we_wb_i && reg_d_wb_is_reg_c_i))) else $error("wrong c select");
  a_load: assert property (@(posedge clk) disable iff (!rst_n) data_req_ex_i && regfile_we_ex_i &&
    (reg_d_ex_is_reg_a_i || reg_d_ex_is_reg_b_i || reg_d_ex_is_reg_c_i) |->
    load_stall_o && deassert_we_o) else $error("load-use hazard not stalled");
  a_csr: assert property (@(posedge clk) disable iff (!rst_n) csr_busy_i && csr_access_id_i |->
    csr_stall_o && deassert_we_o) else $error("csr-use hazard not stalled");
  a_jr_detect: assert property (@(posedge clk) disable iff (!rst_n)
    jump_in_dec_i == BRANCH_JALR && rega_busy |-> jr_stall_o) else $error("jalr hazard missed");
  a_jr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_o |-> !pc_jump) else $error("jump pc set during jalr stall");
  a_jump_once: assert property (@(posedge clk) disable iff (!rst_n)
    pc_jump && !id_ready_i |=> !pc_jump) else $error("jump pc set twice");

  ////////////////////////////////////////////////////////////
  // traps, branches, flush and sleep
  ////////////////////////////////////////////////////////////
  a_sync_exc: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode && !mret_insn_i && int_req_i |-> exc_entry && exc_save_id_o && !irq_ack_o)
    else $error("bad synchronous exception entry");
  a_irq: assert property (@(posedge clk) disable iff (!rst_n)
    in_decode && !mret_insn_i && !int_req_i && ext_req_i |-> exc_entry && exc_save_id_o &&
    irq_ack_o) else $error("bad interrupt entry");
  a_mret: assert property (@(posedge clk) disable iff (!rst_n) in_decode && mret_insn_i |->
    pc_mux_o == PC_ERET && exc_restore_id_o) else $error("bad mret return");
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == DECODE && branch_taken_ex_i && !ext_req_i |->
    pc_set_o && pc_mux_o == PC_BRANCH && !is_decoding_o) else $error("bad branch redirect");
  a_branch_irq: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == DECODE && branch_taken_ex_i && ext_req_i |->
    exc_entry && exc_save_takenbranch_o) else $error("bad interrupt on taken branch");
  a_flush_halt: assert property (@(posedge clk) disable iff (!rst_n) (in_decode && pipe_flush_i) ||
    fsm_state_i == FLUSH_EX || (fsm_state_i == FLUSH_WB && !fetch_enable_i) |->
    halt_if_o && halt_id_o) else $error("pipeline not halted during flush");
  a_sleep_entry: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == FLUSH_WB && !fetch_enable_i |=> !ctrl_busy_o) else $error("no sleep");
  a_sleep_halt: assert property (@(posedge clk) disable iff (!rst_n) fsm_state_i == SLEEP |->
    halt_if_o && halt_id_o && !ctrl_busy_o) else $error("busy or running in SLEEP");
  a_wake: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == SLEEP && (int_req_i || ext_req_i) |=> ctrl_busy_o) else $error("no wakeup");
  a_wake_trap: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_state_i == FIRST_FETCH && ext_req_i |-> pc_set_o && pc_mux_o == PC_EXCEPTION &&
    irq_ack_o && exc_save_if_o) else $error("bad trap entry on wakeup");

endmodule

bind riscv_controller riscv_controller_checker u_checker (.*, .fsm_state_i(u_fsm.state_q));

//--- bench/riscv_controller_tb.sv
////////////////////////////////////////////////////////////
// riscv controller testbench
// drives the pipeline status inputs through boot, operand
// forwarding, stalls, traps and the flush to sleep
// values are checked by the bound assertion checker
////////////////////////////////////////////////////////////

module riscv_controller_tb;

  import riscv_ctrl_pkg::*;

  localparam int CLK_PERIOD      = 40;
  // whole sequence runs in well under 100 cycles
  localparam int WATCHDOG_CYCLES = 200;

  logic clk, rst_n, fetch_enable_i, instr_valid_i, illegal_insn_i, mret_insn_i;
  logic pipe_flush_i, branch_taken_ex_i, int_req_i, ext_req_i, id_ready_i, ex_valid_i;
  logic data_req_ex_i, data_misaligned_i, mult_multicycle_i, csr_busy_i, csr_access_id_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;
  jump_kind_e jump_in_dec_i;
  logic ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o;
  logic exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o;
  logic exc_restore_id_o, halt_if_o, halt_id_o, load_stall_o, csr_stall_o, jr_stall_o;
  pc_sel_e pc_mux_o;
  fw_sel_e operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o, operand_c_fw_mux_sel_o;

  int          errors;
  int          seed;
  int          mis_hits;
  int          mul_hits;
  logic [31:0] rnd;

  riscv_controller u_riscv_controller (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_miss(input string what);
    errors++;
    $display("missed at %0t: %s", $time, what);
  endtask

  // wait a few rising edges for a pc redirect of the given kind
  task automatic expect_pc(input pc_sel_e sel, input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(posedge clk);
      seen = pc_set_o && (pc_mux_o == sel);
    end
    // back on the falling edge for the next stimulus
    @(negedge clk);
    if (!seen) begin
      report_miss(what);
    end
  endtask

  task automatic expect_busy(input logic level, input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(negedge clk);
      seen = (ctrl_busy_o == level);
    end
    if (!seen) begin
      report_miss(what);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d", errors + 1);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    errors   = 0;
    seed     = 3;
    mis_hits = 0;
    mul_hits = 0;
    jump_in_dec_i = BRANCH_NONE;
    {fetch_enable_i, instr_valid_i, illegal_insn_i, mret_insn_i, pipe_flush_i,
     branch_taken_ex_i, int_req_i, ext_req_i, id_ready_i, ex_valid_i, data_req_ex_i,
     data_misaligned_i, mult_multicycle_i, csr_busy_i, csr_access_id_i, regfile_we_ex_i,
     regfile_we_wb_i, regfile_alu_we_fw_i, reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i,
     reg_d_ex_is_reg_c_i, reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i,
     reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // idle in RESET, then boot
    repeat (3) @(negedge clk);
    fetch_enable_i = 1'b1;
    expect_pc(PC_BOOT, "boot pc set after fetch enable");

    // random match and write-enable patterns, still in FIRST_FETCH
    repeat (20) begin
      @(negedge clk);
      rnd = $random(seed);
      {regfile_we_wb_i, regfile_alu_we_fw_i, reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i,
       reg_d_wb_is_reg_c_i, reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i,
       data_misaligned_i, mult_multicycle_i} = rnd[9:0];
      if (data_misaligned_i) begin
        mis_hits++;
      end else if (mult_multicycle_i) begin
        mul_hits++;
      end
    end
    @(negedge clk);
    {regfile_we_wb_i, regfile_alu_we_fw_i, reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i,
     reg_d_wb_is_reg_c_i, reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i,
     data_misaligned_i, mult_multicycle_i} = '0;
    if (mis_hits == 0 || mul_hits == 0) begin
      report_miss("forwarding overrides never exercised");
    end

    // into DECODE, then a load-use hazard on operand b
    id_ready_i = 1'b1;
    @(negedge clk);
    instr_valid_i   = 1'b1;
    data_req_ex_i   = 1'b1;
    regfile_we_ex_i = 1'b1;
    reg_d_ex_is_reg_b_i = 1'b1;
    @(negedge clk);
    if (!(load_stall_o && deassert_we_o)) begin
      report_miss("load stall not raised");
    end
    {data_req_ex_i, regfile_we_ex_i, reg_d_ex_is_reg_b_i} = '0;

    // csr write still in EX while ID reads a csr
    csr_busy_i      = 1'b1;
    csr_access_id_i = 1'b1;
    @(negedge clk);
    {csr_busy_i, csr_access_id_i} = '0;

    // jalr with register a pending in WB, ID holds the instruction
    id_ready_i          = 1'b0;
    jump_in_dec_i       = BRANCH_JALR;
    regfile_we_wb_i     = 1'b1;
    reg_d_wb_is_reg_a_i = 1'b1;
    repeat (3) @(negedge clk);
    if (!jr_stall_o) begin
      report_miss("jalr stall not raised");
    end
    regfile_we_wb_i = 1'b0;
    expect_pc(PC_JUMP, "jump pc set after jalr stall cleared");
    repeat (3) @(negedge clk);
    jump_in_dec_i       = BRANCH_NONE;
    reg_d_wb_is_reg_a_i = 1'b0;
    id_ready_i          = 1'b1;
    @(negedge clk);

    // synchronous exception, then interrupt
    int_req_i = 1'b1;
    expect_pc(PC_EXCEPTION, "exception entry on int_req_i");
    int_req_i = 1'b0;
    ext_req_i = 1'b1;
    expect_pc(PC_EXCEPTION, "interrupt entry on ext_req_i");
    ext_req_i = 1'b0;

    // taken branch alone, then with an interrupt
    branch_taken_ex_i = 1'b1;
    expect_pc(PC_BRANCH, "branch redirect");
    ext_req_i = 1'b1;
    expect_pc(PC_EXCEPTION, "interrupt on taken branch");
    {branch_taken_ex_i, ext_req_i} = '0;

    // mret with fetch enabled returns without a flush
    mret_insn_i = 1'b1;
    expect_pc(PC_ERET, "return on mret");
    mret_insn_i = 1'b0;

    // flush with fetch disabled ends in SLEEP, interrupt wakes it
    fetch_enable_i = 1'b0;
    pipe_flush_i   = 1'b1;
    @(negedge clk);
    pipe_flush_i = 1'b0;
    repeat (2) @(negedge clk);
    ex_valid_i = 1'b1;
    expect_busy(1'b0, "controller idle after flush");
    ex_valid_i = 1'b0;
    ext_req_i  = 1'b1;
    expect_busy(1'b1, "controller busy after wakeup");
    // request still pending in FIRST_FETCH takes the trap there
    @(negedge clk);
    ext_req_i = 1'b0;
    repeat (2) @(negedge clk);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/riscv_controller.sv
////////////////////////////////////////////////////////////
// riscv controller top
// main FSM, hazard unit and forwarding unit side by side
////////////////////////////////////////////////////////////

module riscv_controller (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_enable_i,
  input  logic                       instr_valid_i,
  input  logic                       illegal_insn_i,
  input  logic                       mret_insn_i,
  input  logic                       pipe_flush_i,
  input  logic                       branch_taken_ex_i,
  input  riscv_ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                       int_req_i,
  input  logic                       ext_req_i,
  input  logic                       id_ready_i,
  input  logic                       ex_valid_i,
  input  logic                       data_req_ex_i,
  input  logic                       data_misaligned_i,
  input  logic                       mult_multicycle_i,
  input  logic                       regfile_we_ex_i,
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic                       reg_d_ex_is_reg_a_i,
  input  logic                       reg_d_ex_is_reg_b_i,
  input  logic                       reg_d_ex_is_reg_c_i,
  input  logic                       reg_d_wb_is_reg_a_i,
  input  logic                       reg_d_wb_is_reg_b_i,
  input  logic                       reg_d_wb_is_reg_c_i,
  input  logic                       reg_d_alu_is_reg_a_i,
  input  logic                       reg_d_alu_is_reg_b_i,
  input  logic                       reg_d_alu_is_reg_c_i,
  input  logic                       csr_busy_i,
  input  logic                       csr_access_id_i,
  output logic                       ctrl_busy_o,
  output logic                       is_decoding_o,
  output logic                       deassert_we_o,
  output logic                       instr_req_o,
  output logic                       pc_set_o,
  output riscv_ctrl_pkg::pc_sel_e    pc_mux_o,
  output logic                       exc_ack_o,
  output logic                       irq_ack_o,
  output logic                       exc_save_if_o,
  output logic                       exc_save_id_o,
  output logic                       exc_save_takenbranch_o,
  output logic                       exc_restore_id_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o,
  output logic                       load_stall_o,
  output logic                       csr_stall_o,
  output logic                       jr_stall_o,
  output riscv_ctrl_pkg::fw_sel_e    operand_a_fw_mux_sel_o,
  output riscv_ctrl_pkg::fw_sel_e    operand_b_fw_mux_sel_o,
  output riscv_ctrl_pkg::fw_sel_e    operand_c_fw_mux_sel_o
);

  // FSM waits on the jalr hazard before setting the pc
  riscv_ctrl_fsm u_fsm (.*, .jr_stall_i(jr_stall_o));

  // hazard unit sees the decode state for the we deassert
  // match and write-enable inputs are shared with u_fwd
  riscv_hazard_unit u_hazard (.*, .is_decoding_i(is_decoding_o));

  riscv_fwd_unit u_fwd (.*);

endmodule

//--- design/riscv_ctrl_cfg.svh
////////////////////////////////////////////////////////////
// riscv controller configuration
// field widths shared by the controller package
////////////////////////////////////////////////////////////

`ifndef RISCV_CTRL_CFG_SVH
`define RISCV_CTRL_CFG_SVH

// main FSM state encoding
// 7 states, fits in 3 bits
`define RISCV_CTRL_STATE_W 3

// pc mux select toward the fetch stage
// keeps room for the unused debug npc code
`define RISCV_PC_SEL_W 3

// jump kind coming out of the decoder
`define RISCV_JUMP_W 2

// operand forwarding mux select
// regfile, EX path or WB path
`define RISCV_FW_SEL_W 2

`endif

//--- design/riscv_ctrl_fsm.sv
////////////////////////////////////////////////////////////
// riscv main control FSM
// boot, sleep, decode and pipeline flush sequencing,
// jump / mret pc redirect and exception or interrupt entry
////////////////////////////////////////////////////////////

module riscv_ctrl_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_enable_i,
  input  logic                       instr_valid_i,
  input  logic                       mret_insn_i,
  input  logic                       pipe_flush_i,
  input  logic                       branch_taken_ex_i,
  input  riscv_ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                       int_req_i,
  input  logic                       ext_req_i,
  input  logic                       id_ready_i,
  input  logic                       ex_valid_i,
  input  logic                       jr_stall_i,
  output logic                       ctrl_busy_o,
  output logic                       is_decoding_o,
  output logic                       instr_req_o,
  output logic                       pc_set_o,
  output riscv_ctrl_pkg::pc_sel_e    pc_mux_o,
  output logic                       exc_ack_o,
  output logic                       irq_ack_o,
  output logic                       exc_save_if_o,
  output logic                       exc_save_id_o,
  output logic                       exc_save_takenbranch_o,
  output logic                       exc_restore_id_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o
);

  import riscv_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        jump_done_q;
  logic        jump_done_d;
  logic        exc_req;
  logic        is_jump;
  logic        flush_req;

  // any pending trap, synchronous or external
  assign exc_req = int_req_i | ext_req_i;

  // unconditional jumps have their target ready in decode
  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  // wfi, or mret going back to sleep
  assign flush_req = pipe_flush_i | (mret_insn_i & ~fetch_enable_i);

  ////////////////////////////////////////////////////////////
  // next state and output decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d                = state_q;
    jump_done_d            = jump_done_q;
    instr_req_o            = 1'b1;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    irq_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch pc
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wake on fetch enable or a trap
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // a wakeup trap redirects right away, pc is still in IF
        if (exc_req) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          irq_ack_o     = ext_req_i;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // only decode when no taken branch sits in EX
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          // jal / jalr, wait out the jr hazard, redirect only once
          if (is_jump) begin
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // mret first, then ecall/illegal, then interrupts
          if (mret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (int_req_i) begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            // keep the trapping instruction out of EX
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end else if (ext_req_i) begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            irq_ack_o     = 1'b1;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // drain EX and WB before sleeping or resuming
          if (flush_req) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // interrupt with an empty ID stage, return pc comes from IF
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          irq_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch in EX wins over whatever is in ID
        if (branch_taken_ex_i) begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
          // interrupt on a taken branch, return to the branch target
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            irq_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // nop into EX, wait for the last instruction to finish
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // nop into WB, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and jump-done registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // flag lives until ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

//--- design/riscv_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// riscv controller package
// enum types for the FSM, the pc mux, the jump kind and
// the operand forwarding selects
////////////////////////////////////////////////////////////

package riscv_ctrl_pkg;

  `include "riscv_ctrl_cfg.svh"

  // main controller states
  typedef enum logic [`RISCV_CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  // next pc source, encoding matches the fetch stage mux
  typedef enum logic [`RISCV_PC_SEL_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_sel_e;

  // kind of control transfer seen in decode
  typedef enum logic [`RISCV_JUMP_W-1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source in the ID stage
  typedef enum logic [`RISCV_FW_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

//--- design/riscv_fwd_unit.sv
////////////////////////////////////////////////////////////
// riscv forwarding unit
// operand a, b and c source selects for the ID stage
////////////////////////////////////////////////////////////

module riscv_fwd_unit (
  input  logic                    regfile_we_wb_i,
  input  logic                    regfile_alu_we_fw_i,
  input  logic                    reg_d_wb_is_reg_a_i,
  input  logic                    reg_d_wb_is_reg_b_i,
  input  logic                    reg_d_wb_is_reg_c_i,
  input  logic                    reg_d_alu_is_reg_a_i,
  input  logic                    reg_d_alu_is_reg_b_i,
  input  logic                    reg_d_alu_is_reg_c_i,
  input  logic                    data_misaligned_i,
  input  logic                    mult_multicycle_i,
  output riscv_ctrl_pkg::fw_sel_e operand_a_fw_mux_sel_o,
  output riscv_ctrl_pkg::fw_sel_e operand_b_fw_mux_sel_o,
  output riscv_ctrl_pkg::fw_sel_e operand_c_fw_mux_sel_o
);

  import riscv_ctrl_pkg::*;

  // newest value wins, ALU path before WB before regfile
  function automatic fw_sel_e base_sel(input logic wb_hit, input logic alu_hit);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (regfile_we_wb_i && wb_hit) begin
      sel = SEL_FW_WB;
    end
    if (regfile_alu_we_fw_i && alu_hit) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    operand_a_fw_mux_sel_o = base_sel(reg_d_wb_is_reg_a_i, reg_d_alu_is_reg_a_i);
    operand_b_fw_mux_sel_o = base_sel(reg_d_wb_is_reg_b_i, reg_d_alu_is_reg_b_i);
    operand_c_fw_mux_sel_o = base_sel(reg_d_wb_is_reg_c_i, reg_d_alu_is_reg_c_i);

    // second half of a misaligned access
    // address comes back from EX, offset from the regfile
    if (data_misaligned_i) begin
      operand_a_fw_mux_sel_o = SEL_FW_EX;
      operand_b_fw_mux_sel_o = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multicycle mul keeps its partial result on operand c
      operand_c_fw_mux_sel_o = SEL_FW_EX;
    end
  end

endmodule

//--- design/riscv_hazard_unit.sv
////////////////////////////////////////////////////////////
// riscv hazard unit
// load-use, csr-use and jump-register stall detection,
// plus the write-enable deassert for the ID stage
////////////////////////////////////////////////////////////

module riscv_hazard_unit (
  input  logic                       is_decoding_i,
  input  logic                       illegal_insn_i,
  input  logic                       data_req_ex_i,
  input  logic                       regfile_we_ex_i,
  input  logic                       regfile_we_wb_i,
  input  logic                       regfile_alu_we_fw_i,
  input  logic                       reg_d_ex_is_reg_a_i,
  input  logic                       reg_d_ex_is_reg_b_i,
  input  logic                       reg_d_ex_is_reg_c_i,
  input  logic                       reg_d_wb_is_reg_a_i,
  input  logic                       reg_d_alu_is_reg_a_i,
  input  logic                       csr_busy_i,
  input  logic                       csr_access_id_i,
  input  riscv_ctrl_pkg::jump_kind_e jump_in_dec_i,
  output logic                       load_stall_o,
  output logic                       csr_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o
);

  import riscv_ctrl_pkg::*;

  logic ex_dest_hit;
  logic rega_pending;

  // EX destination is one of the ID sources
  assign ex_dest_hit = reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i | reg_d_ex_is_reg_c_i;

  // load data arrives only after WB, so stall a dependent op
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & ex_dest_hit;

  // coarse check, any csr access in ID waits for a csr write in EX
  assign csr_stall_o = csr_busy_i & csr_access_id_i;

  // register a still in flight on some write path
  assign rega_pending = (regfile_we_wb_i & reg_d_wb_is_reg_a_i) |
                        (regfile_we_ex_i & reg_d_ex_is_reg_a_i) |
                        (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);

  // jalr target is not forwarded to the pc, always wait
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & rega_pending;

  ////////////////////////////////////////////////////////////
  // write-enable deassert
  ////////////////////////////////////////////////////////////

  // no register write for a stalled, illegal or non-decoded op
  assign deassert_we_o = ~is_decoding_i |
                         illegal_insn_i |
                         load_stall_o   |
                         csr_stall_o    |
                         jr_stall_o;

endmodule

//--- riscv_controller.f
+incdir+design
design/riscv_ctrl_pkg.sv
design/riscv_ctrl_fsm.sv
design/riscv_hazard_unit.sv
design/riscv_fwd_unit.sv
design/riscv_controller.sv
bench/riscv_controller_checker.sv
bench/riscv_controller_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the riscv controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module riscv_controller_tb \
  -f riscv_controller.f

# an assertion stop exits non-zero, the output search still decides
output="$(./obj_dir/Vriscv_controller_tb || true)"
echo "${output}"

if grep -qF -- "*** PASSED ***" <<< "${output}"; then
  exit 0
fi
exit 1
